// File: project.f
+incdir+.
ex_pkg.sv
cla_adder.sv
alu_unit.sv
branch_unit.sv
ex_stage.sv
ex_stage_sva.sv
ex_stage_checker.sv
ex_stage_tb.sv

// File: run.sh
#!/bin/sh
# build and run the ex_stage testbench with Verilator
verilator --binary --timing --assert -f project.f --top-module ex_stage_tb -o sim \
    > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim > sim.log 2>&1 || echo "simulator exited with an error" >> sim.log
cat sim.log
grep -q "Simulation failed" sim.log && exit 1 || grep -q "Simulation passed" sim.log || exit 1

// File: ex_stage_tb.sv
`include "ex_consts.svh"

module ex_stage_tb import ex_pkg::*; ();
    localparam int N_DIR = 36;
    localparam int NROWS = N_DIR + 40;
    localparam int TIMEOUT = 200;

    logic clk, rst, chk_en;
    opcode_t opcode;
    funct3_t func3;
    funct7_t func7;
    xlen_t imm, data1, data2, result, exp_result;
    pc_t pc, pc_branch, exp_pc_branch;
    logic is_branch, is_load, mem_rw, exp_is_branch, exp_is_load, exp_mem_rw;
    int errors, checks, wait_cnt;

    // stimulus table and expected outputs
    opcode_t t_opc[NROWS];
    funct3_t t_f3[NROWS];
    funct7_t t_f7[NROWS];
    xlen_t t_imm[NROWS], t_d1[NROWS], t_d2[NROWS], t_res[NROWS];
    pc_t t_pc[NROWS], t_pcb[NROWS];
    logic t_isb[NROWS], t_ld[NROWS], t_st[NROWS];
    xlen_t m_res;
    pc_t m_pcb;
    logic m_isb;
    logic [63:0] rng;
    opcode_t opc_list[12] = '{`OPC_OP, `OPC_OP_32, `OPC_OP_IMM, `OPC_OP_IMM_32, `OPC_LOAD,
        `OPC_STORE, `OPC_BRANCH, `OPC_JAL, `OPC_JALR, `OPC_AUIPC, `OPC_LUI, 7'h7f};

    ex_stage DUT (.*);
    ex_stage_checker u_chk (.en(chk_en), .*);
    bind ex_stage ex_stage_sva u_sva (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic xlen_t sx32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic logic [63:0] xorshift(input logic [63:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 7);
        return x ^ (x << 17);
    endfunction

    function automatic void put(input int i, input opcode_t o, input funct3_t f3,
            input funct7_t f7, input xlen_t im, input xlen_t d1, input xlen_t d2, input pc_t p);
        t_opc[i] = o;
        t_f3[i] = f3;
        t_f7[i] = f7;
        t_imm[i] = im;
        t_d1[i] = d1;
        t_d2[i] = d2;
        t_pc[i] = p;
    endfunction

    // reference model that carries held values in m_res, m_pcb and m_isb
    function automatic void model(input int i);
        logic reg_op, word, alt, ok, cond;
        xlen_t a, b, r, up, sra;
        logic [5:0] sh;
        reg_op = t_opc[i] == `OPC_OP || t_opc[i] == `OPC_OP_32;
        word = t_opc[i] == `OPC_OP_32 || t_opc[i] == `OPC_OP_IMM_32;
        a = word ? sx32(t_d1[i][31:0]) : t_d1[i];
        b = reg_op ? t_d2[i] : t_imm[i];
        b = word ? sx32(b[31:0]) : b;
        sh = word ? {1'b0, b[4:0]} : b[5:0];
        sra = $signed(a) >>> sh;
        alt = reg_op ? t_f7[i] == `F7_ALT : t_f7[i][5];
        ok = !reg_op || t_f7[i] == `F7_BASE || (t_f7[i] == `F7_ALT &&
             (t_f3[i] == `F3_ADD || t_f3[i] == `F3_SRL));
        case (t_f3[i])
            `F3_ADD: r = (reg_op && alt) ? a - b : a + b;
            `F3_SLL: r = a << sh;
            `F3_SLT: r = ($signed(a) < $signed(b)) ? 1 : 0;
            `F3_SLTU: r = (a < b) ? 1 : 0;
            `F3_XOR: r = a ^ b;
            `F3_SRL: r = alt ? sra :
                         (word ? {32'b0, t_d1[i][31:0]} >> sh : t_d1[i] >> sh);
            `F3_OR: r = a | b;
            default: r = a & b;
        endcase
        up = sx32({t_imm[i][19:0], 12'b0});
        case (t_opc[i])
            `OPC_OP, `OPC_OP_32, `OPC_OP_IMM, `OPC_OP_IMM_32: begin
                if (ok) begin
                    m_res = word ? sx32(r[31:0]) : r;
                end
            end
            `OPC_LUI: m_res = up;
            `OPC_AUIPC: m_res = {32'b0, t_pc[i]} + up;
            `OPC_LOAD, `OPC_STORE: ;
            `OPC_BRANCH: begin
                case (t_f3[i])
                    `F3_BEQ: cond = t_d1[i] == t_d2[i];
                    `F3_BNE: cond = t_d1[i] != t_d2[i];
                    `F3_BLT: cond = $signed(t_d1[i]) < $signed(t_d2[i]);
                    `F3_BGE: cond = $signed(t_d1[i]) >= $signed(t_d2[i]);
                    `F3_BLTU: cond = t_d1[i] < t_d2[i];
                    `F3_BGEU: cond = t_d1[i] >= t_d2[i];
                    default: cond = 1'b0;
                endcase
                m_isb = cond;
                m_pcb = cond ? t_pc[i] + t_imm[i][31:0] : t_pc[i] + 32'd4;
            end
            `OPC_JAL, `OPC_JALR: begin
                m_isb = 1'b1;
                m_pcb = (t_opc[i] == `OPC_JALR ? t_d1[i][31:0] : t_pc[i]) + t_imm[i][31:0];
            end
            default: m_res = '0;
        endcase
        t_res[i] = m_res;
        t_pcb[i] = m_pcb;
        t_isb[i] = m_isb;
        t_ld[i] = t_opc[i] == `OPC_LOAD;
        t_st[i] = t_opc[i] == `OPC_STORE;
    endfunction

    initial begin
        {opcode, func3, func7, imm, data1, data2, pc, chk_en, rst} = '0;
        {exp_result, exp_pc_branch, exp_is_branch, exp_is_load, exp_mem_rw} = '0;
        #2 rst = 1'b1;
        put(0, `OPC_OP, `F3_ADD, `F7_BASE, 0, 64'hffff_ffff, 1, 0);
        put(1, `OPC_OP, `F3_ADD, `F7_ALT, 0, 0, 1, 0);
        put(2, `OPC_OP, `F3_SLL, `F7_BASE, 0, 1, 40, 0);
        put(3, `OPC_OP, `F3_SRL, `F7_ALT, 0, 64'h8000_0000_0000_0000, 36, 0);
        put(4, `OPC_OP, `F3_SRL, `F7_BASE, 0, 64'h8000_0000_0000_0000, 36, 0);
        put(5, `OPC_OP, `F3_SLT, `F7_BASE, 0, '1, 1, 0);
        put(6, `OPC_OP, `F3_SLTU, `F7_BASE, 0, '1, 1, 0);
        put(7, `OPC_OP_IMM, `F3_XOR, 0, 64'hffff_ffff_ffff_00ff, 64'h0f0f, 0, 0);
        put(8, `OPC_OP_32, `F3_ADD, `F7_BASE, 0, 64'h7fff_ffff, 1, 0);
        put(9, `OPC_OP, `F3_ADD, 7'h01, 0, 5, 5, 0);
        put(10, `OPC_OP_32, `F3_ADD, `F7_ALT, 0, 0, 1, 0);
        put(11, `OPC_OP_32, `F3_SLL, `F7_BASE, 0, 1, 63, 0);
        put(12, `OPC_OP_32, `F3_SRL, `F7_ALT, 0, 64'h8000_0000, 4, 0);
        put(13, `OPC_OP_32, `F3_SRL, `F7_BASE, 0, 64'h8000_0000, 4, 0);
        put(14, `OPC_OP_IMM_32, `F3_ADD, 0, -64'd6, 64'h1234_5678_0000_0010, 0, 0);
        put(15, `OPC_LUI, 0, 0, 64'h80000, 0, 0, 0);
        put(16, `OPC_AUIPC, 0, 0, 1, 0, 0, 32'h1000);
        put(17, `OPC_BRANCH, `F3_BEQ, 0, 64'h40, 5, 5, 32'h100);
        put(18, `OPC_BRANCH, `F3_BEQ, 0, 64'h40, 5, 6, 32'h200);
        put(19, `OPC_BRANCH, `F3_BLT, 0, -64'd8, '1, 1, 32'h300);
        put(20, `OPC_BRANCH, `F3_BLTU, 0, -64'd8, '1, 1, 32'h300);
        put(21, `OPC_BRANCH, `F3_BGE, 0, 64'h10, 1, '1, 32'h400);
        put(22, `OPC_BRANCH, `F3_BGEU, 0, 64'h10, 1, '1, 32'h400);
        put(23, `OPC_JAL, 0, 0, 64'h100, 0, 0, 32'h600);
        put(24, `OPC_JALR, 0, 0, 64'h10, 64'h1001, 0, 32'h800);
        put(25, `OPC_LOAD, 0, 0, 8, 1, 2, 32'h900);
        put(26, `OPC_STORE, 0, 0, 8, 1, 2, 32'h904);
        put(27, 7'h7f, 0, 0, 0, 0, 0, 0);
        put(28, `OPC_OP, `F3_OR, `F7_BASE, 0, 64'hf0f0_0000_0000_00f0, 64'h0f00_0000_0000_000f, 0);
        put(29, `OPC_OP, `F3_AND, `F7_BASE, 0, 64'hff00_ff00_ff00_ff00, 64'h0ff0_0ff0_0ff0_0ff0, 0);
        put(30, `OPC_BRANCH, `F3_BNE, 0, 64'h20, 5, 6, 32'h500);
        put(31, `OPC_BRANCH, `F3_BNE, 0, 64'h20, 7, 7, 32'h500);
        put(32, `OPC_BRANCH, `F3_BLT, 0, -64'd8, 1, '1, 32'h700);
        put(33, `OPC_BRANCH, `F3_BLTU, 0, -64'd8, 1, '1, 32'h700);
        put(34, `OPC_BRANCH, `F3_BGE, 0, 64'h10, '1, 1, 32'ha00);
        put(35, `OPC_BRANCH, `F3_BGEU, 0, 64'h10, '1, 1, 32'ha00);
        rng = 64'd67478;
        for (int i = N_DIR; i < NROWS; i++) begin
            rng = xorshift(rng);
            put(i, opc_list[rng % 12], rng[18:16], rng[4:3] == 0 ? rng[11:5] :
                (rng[12] ? `F7_ALT : `F7_BASE), xorshift(rng + 1), xorshift(rng + 2),
                rng[13] ? xorshift(rng + 2) : xorshift(rng + 3), rng[63:32]);
        end
        {m_res, m_pcb, m_isb} = '0;
        for (int i = 0; i < NROWS; i++) model(i);
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        chk_en <= 1'b1;
        for (int i = 0; i <= NROWS; i++) begin
            @(posedge clk);
            if (i < NROWS) begin
                {opcode, func3, func7} <= {t_opc[i], t_f3[i], t_f7[i]};
                {imm, data1, data2, pc} <= {t_imm[i], t_d1[i], t_d2[i], t_pc[i]};
            end
            if (i > 0) begin
                {exp_result, exp_pc_branch, exp_is_branch} <= {t_res[i-1], t_pcb[i-1], t_isb[i-1]};
                {exp_is_load, exp_mem_rw} <= {t_ld[i-1], t_st[i-1]};
            end
        end
        // two idle cycles after reset, then one per row
        wait_cnt = 0;
        while (checks < NROWS + 2 && wait_cnt < TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        chk_en <= 1'b0;
        if (checks < NROWS + 2) begin
            $display("timeout: checker did not see every row");
        end
        $display("errors: %0d mismatches in %0d checked cycles", errors, checks);
        if (errors == 0 && checks >= NROWS + 2) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: ex_stage_checker.sv
module ex_stage_checker import ex_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  en,
    input  xlen_t result,
    input  pc_t   pc_branch,
    input  logic  is_branch,
    input  logic  is_load,
    input  logic  mem_rw,
    input  xlen_t exp_result,
    input  pc_t   exp_pc_branch,
    input  logic  exp_is_branch,
    input  logic  exp_is_load,
    input  logic  exp_mem_rw,
    output int    errors,
    output int    checks
);
    initial begin
        errors = 0;
        checks = 0;
    end

    task automatic compare(input string name, input xlen_t exp_v, input xlen_t got_v);
        if (got_v !== exp_v) begin
            errors++;
            $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, got_v);
        end
    endtask

    // outputs settle after the rising edge, so compare on the falling one
    always @(negedge clk) begin
        if (en && !rst) begin
            compare("result", exp_result, result);
            compare("pc_branch", xlen_t'(exp_pc_branch), xlen_t'(pc_branch));
            compare("is_branch", xlen_t'(exp_is_branch), xlen_t'(is_branch));
            compare("is_load", xlen_t'(exp_is_load), xlen_t'(is_load));
            compare("mem_rw", xlen_t'(exp_mem_rw), xlen_t'(mem_rw));
            checks++;
        end
    end

endmodule

// File: ex_stage_sva.sv
`include "ex_consts.svh"

module ex_stage_sva import ex_pkg::*; (
    input logic    clk,
    input logic    rst,
    input opcode_t opcode,
    input pc_t     pc_branch,
    input logic    is_branch,
    input xlen_t   result,
    input logic    mem_rw,
    input logic    is_load
);
    a_mem_flags: assert property (@(posedge clk) disable iff (rst) !(is_load && mem_rw))
        else $error("is_load and mem_rw both high");

    a_reset_zero: assert property (@(posedge clk) rst |->
        (result == '0 && pc_branch == '0 && !is_branch && !mem_rw && !is_load))
        else $error("outputs not zero during reset");

    // is_branch only rises after a control-flow opcode
    a_branch_rise: assert property (@(posedge clk) disable iff (rst) $rose(is_branch) |->
        ($past(opcode) inside {`OPC_BRANCH, `OPC_JAL, `OPC_JALR}))
        else $error("is_branch rose without a branch or jump");

endmodule

// File: ex_stage.sv
`include "ex_consts.svh"

module ex_stage import ex_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  opcode_t opcode,
    input  funct3_t func3,
    input  funct7_t func7,
    input  xlen_t   imm,
    input  xlen_t   data1,
    input  xlen_t   data2,
    input  pc_t     pc,
    output pc_t     pc_branch,
    output logic    is_branch,
    output xlen_t   result,
    output logic    mem_rw,
    output logic    is_load
);
    xlen_t alu_result;
    logic  alu_update;
    pc_t   target;
    logic  taken;
    logic  pc_update;
    logic  load_dec;
    logic  store_dec;

    alu_unit u_alu (
        .opcode     (opcode),
        .func3      (func3),
        .func7      (func7),
        .imm        (imm),
        .data1      (data1),
        .data2      (data2),
        .pc         (pc),
        .alu_result (alu_result),
        .alu_update (alu_update)
    );

    branch_unit u_branch (
        .opcode    (opcode),
        .func3     (func3),
        .imm       (imm),
        .data1     (data1),
        .data2     (data2),
        .pc        (pc),
        .target    (target),
        .taken     (taken),
        .pc_update (pc_update)
    );

    // memory flags, 0 for anything but load and store
    assign load_dec  = (opcode == `OPC_LOAD);
    assign store_dec = (opcode == `OPC_STORE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            is_load <= 1'b0;
            mem_rw  <= 1'b0;
        end else begin
            is_load <= load_dec;
            mem_rw  <= store_dec;
        end
    end

    // holds across loads, stores and control flow
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result <= '0;
        end else if (alu_update) begin
            result <= alu_result;
        end
    end

    // holds when the opcode is not a branch or jump
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc_branch <= '0;
            is_branch <= 1'b0;
        end else if (pc_update) begin
            pc_branch <= target;
            is_branch <= taken;
        end
    end

endmodule

// File: branch_unit.sv
`include "ex_consts.svh"

module branch_unit import ex_pkg::*; (
    input  opcode_t opcode,
    input  funct3_t func3,
    input  xlen_t   imm,
    input  xlen_t   data1,
    input  xlen_t   data2,
    input  pc_t     pc,
    output pc_t     target,
    output logic    taken,
    output logic    pc_update
);
    localparam pc_t PC_STEP = 4;

    logic is_br;
    logic is_jal;
    logic is_jalr;
    logic cond;
    pc_t  base;
    pc_t  jump_target;
    pc_t  next_pc;

    assign is_br   = (opcode == `OPC_BRANCH);
    assign is_jal  = (opcode == `OPC_JAL);
    assign is_jalr = (opcode == `OPC_JALR);

    // jalr adds to rs1, bit 0 kept
    assign base = is_jalr ? data1[`PC_W-1:0] : pc;

    cla_adder #(
        .WIDTH(`PC_W)
    ) u_target_add (
        .a    (base),
        .b    (imm[`PC_W-1:0]),
        .cin  (1'b0),
        .sum  (jump_target),
        .cout ()
    );

    cla_adder #(
        .WIDTH(`PC_W)
    ) u_next_add (
        .a    (pc),
        .b    (PC_STEP),
        .cin  (1'b0),
        .sum  (next_pc),
        .cout ()
    );

    always_comb begin
        case (func3)
            `F3_BEQ:  cond = (data1 == data2);
            `F3_BNE:  cond = (data1 != data2);
            `F3_BLT:  cond = ($signed(data1) < $signed(data2));
            `F3_BGE:  cond = ($signed(data1) >= $signed(data2));
            `F3_BLTU: cond = (data1 < data2);
            `F3_BGEU: cond = (data1 >= data2);
            default:  cond = 1'b0;
        endcase
    end

    assign taken     = is_jal || is_jalr || (is_br && cond);
    assign target    = taken ? jump_target : next_pc;
    assign pc_update = is_br || is_jal || is_jalr;

endmodule

// File: alu_unit.sv
`include "ex_consts.svh"

module alu_unit import ex_pkg::*; (
    input  opcode_t opcode,
    input  funct3_t func3,
    input  funct7_t func7,
    input  xlen_t   imm,
    input  xlen_t   data1,
    input  xlen_t   data2,
    input  pc_t     pc,
    output xlen_t   alu_result,
    output logic    alu_update
);
    logic   is_reg;
    logic   is_imm;
    logic   is_word;
    logic   is_lui;
    logic   is_auipc;
    logic   is_other;
    logic   funct_ok;
    logic   do_sub;
    logic   do_sra;
    xlen_t  op_a;
    xlen_t  op_b;
    xlen_t  upper_imm;
    xlen_t  add_a;
    xlen_t  add_b;
    xlen_t  add_sum;
    shamt_t shamt;
    word_t  word_a;
    xlen_t  srl_src;
    xlen_t  sra_res;
    xlen_t  calc_res;

    function automatic xlen_t sext_word(input word_t w);
        return {{(`XLEN - 32){w[31]}}, w};
    endfunction

    assign is_reg   = (opcode == `OPC_OP) || (opcode == `OPC_OP_32);
    assign is_imm   = (opcode == `OPC_OP_IMM) || (opcode == `OPC_OP_IMM_32);
    assign is_word  = (opcode == `OPC_OP_32) || (opcode == `OPC_OP_IMM_32);
    assign is_lui   = (opcode == `OPC_LUI);
    assign is_auipc = (opcode == `OPC_AUIPC);

    // handled elsewhere in the stage
    assign is_other = (opcode == `OPC_LOAD) || (opcode == `OPC_STORE) ||
                      (opcode == `OPC_BRANCH) || (opcode == `OPC_JAL) ||
                      (opcode == `OPC_JALR);

    // register forms accept alt funct7 only for sub and sra
    assign funct_ok = !is_reg || (func7 == `F7_BASE) ||
                      ((func7 == `F7_ALT) && ((func3 == `F3_ADD) || (func3 == `F3_SRL)));
    assign do_sub   = is_reg && (func3 == `F3_ADD) && (func7 == `F7_ALT);
    // immediate shifts put shamt[5] in func7[0], so only bit 5 picks sra
    assign do_sra   = is_reg ? (func7 == `F7_ALT) : func7[5];

    // word forms work on sign-extended low halves
    assign op_a = is_word ? sext_word(data1[31:0]) : data1;
    always_comb begin
        if (is_reg) begin
            op_b = is_word ? sext_word(data2[31:0]) : data2;
        end else begin
            op_b = is_word ? sext_word(imm[31:0]) : imm;
        end
    end

    assign upper_imm = {{(`XLEN - 32){imm[19]}}, imm[19:0], 12'b0};

    // one adder for add, sub and auipc
    assign add_a = is_auipc ? {{(`XLEN - `PC_W){1'b0}}, pc} : op_a;
    assign add_b = is_auipc ? upper_imm : (do_sub ? ~op_b : op_b);

    cla_adder #(
        .WIDTH(`XLEN)
    ) u_add (
        .a    (add_a),
        .b    (add_b),
        .cin  (do_sub),
        .sum  (add_sum),
        .cout ()
    );

    assign shamt   = is_word ? {1'b0, op_b[4:0]} : op_b[5:0];
    assign word_a  = data1[31:0];
    assign srl_src = is_word ? {{(`XLEN - 32){1'b0}}, word_a} : data1;
    assign sra_res = $signed(op_a) >>> shamt;

    always_comb begin
        case (func3)
            `F3_ADD:  calc_res = add_sum;
            `F3_SLL:  calc_res = op_a << shamt;
            `F3_SLT:  calc_res = {{(`XLEN - 1){1'b0}}, $signed(op_a) < $signed(op_b)};
            `F3_SLTU: calc_res = {{(`XLEN - 1){1'b0}}, op_a < op_b};
            `F3_XOR:  calc_res = op_a ^ op_b;
            `F3_SRL:  calc_res = do_sra ? sra_res : (srl_src >> shamt);
            `F3_OR:   calc_res = op_a | op_b;
            default:  calc_res = op_a & op_b;
        endcase
    end

    always_comb begin
        alu_update = 1'b0;
        alu_result = '0;
        if (is_reg || is_imm) begin
            alu_update = funct_ok;
            alu_result = is_word ? sext_word(calc_res[31:0]) : calc_res;
        end else if (is_lui) begin
            alu_update = 1'b1;
            alu_result = upper_imm;
        end else if (is_auipc) begin
            alu_update = 1'b1;
            alu_result = add_sum;
        end else if (!is_other) begin
            // unknown opcode clears the result
            alu_update = 1'b1;
        end
    end

endmodule

// File: cla_adder.sv
`include "ex_consts.svh"

module cla_adder #(
    parameter int WIDTH = 64
) (
    input  logic [WIDTH-1:0] a,
    input  logic [WIDTH-1:0] b,
    input  logic             cin,
    output logic [WIDTH-1:0] sum,
    output logic             cout
);
    localparam int GW   = `CLA_GROUP;
    localparam int NGRP = WIDTH / GW;

    logic [WIDTH-1:0] gen;
    logic [WIDTH-1:0] prop;
    logic [NGRP:0]    grp_carry;

    assign gen          = a & b;
    assign prop         = a ^ b;
    assign grp_carry[0] = cin;

    genvar gi;
    generate
        for (gi = 0; gi < NGRP; gi++) begin : g_grp
            logic [GW-1:0] g;
            logic [GW-1:0] p;
            logic [GW:0]   c;

            assign g = gen[gi*GW +: GW];
            assign p = prop[gi*GW +: GW];

            // every carry expanded straight from the group carry-in
            always_comb begin
                logic run_p;
                logic run_c;
                c[0] = grp_carry[gi];
                for (int k = 0; k < GW; k++) begin
                    run_p = 1'b1;
                    run_c = 1'b0;
                    for (int j = k; j >= 0; j--) begin
                        run_c = run_c | (run_p & g[j]);
                        run_p = run_p & p[j];
                    end
                    c[k+1] = run_c | (run_p & grp_carry[gi]);
                end
            end

            assign sum[gi*GW +: GW]  = p ^ c[GW-1:0];
            assign grp_carry[gi + 1] = c[GW];
        end
    endgenerate

    assign cout = grp_carry[NGRP];

endmodule

// File: ex_pkg.sv
`include "ex_consts.svh"

package ex_pkg;

    // full-width operand or result
    typedef logic [`XLEN-1:0] xlen_t;

    // word-form value
    typedef logic [31:0] word_t;

    // instruction address
    typedef logic [`PC_W-1:0] pc_t;

    // decoded instruction fields
    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // shift amount, word forms use the low 5 bits
    typedef logic [5:0] shamt_t;

endpackage

// File: ex_consts.svh
`ifndef EX_CONSTS_SVH
`define EX_CONSTS_SVH

// datapath widths
`define XLEN        64
`define PC_W        32
`define CLA_GROUP   8

// major opcodes
`define OPC_OP          7'b0110011
`define OPC_OP_32       7'b0111011
`define OPC_OP_IMM      7'b0010011
`define OPC_OP_IMM_32   7'b0011011
`define OPC_LOAD        7'b0000011
`define OPC_STORE       7'b0100011
`define OPC_BRANCH      7'b1100011
`define OPC_JAL         7'b1101111
`define OPC_JALR        7'b1100111
`define OPC_AUIPC       7'b0010111
`define OPC_LUI         7'b0110111

// funct3 for alu ops
`define F3_ADD      3'b000
`define F3_SLL      3'b001
`define F3_SLT      3'b010
`define F3_SLTU     3'b011
`define F3_XOR      3'b100
`define F3_SRL      3'b101
`define F3_OR       3'b110
`define F3_AND      3'b111

// funct3 for branches
`define F3_BEQ      3'b000
`define F3_BNE      3'b001
`define F3_BLT      3'b100
`define F3_BGE      3'b101
`define F3_BLTU     3'b110
`define F3_BGEU     3'b111

// funct7, alt selects sub and sra
`define F7_BASE     7'b0000000
`define F7_ALT      7'b0100000

`endif
